// ==== video_consts.svh ====
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// horizontal timing in pixels
`define H_VISIBLE       8
`define H_FRONT         2
`define H_SYNC          2
`define H_BACK          2
`define H_TOTAL         (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines
`define V_VISIBLE       4
`define V_FRONT         1
`define V_SYNC          1
`define V_BACK          1
`define V_TOTAL         (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

// palette size
`define PAL_DEPTH       64
`define PAL_AWIDTH      6

// cpu register numbers
`define REG_INTR_MASK   0
`define REG_INTR_CLEAR  1
`define REG_SCROLL_A    2
`define REG_SCROLL_B    3
`define REG_PAL_ADDR    4
`define REG_PAL_DATA    5
`define REG_LINE_CMP    6

`endif

// ==== vid_types_pkg.sv ====
`include "video_consts.svh"

package vid_types_pkg;

typedef struct packed {
    logic de;                               // visible pixel
    logic hsync;                            // active high
    logic vsync;                            // active high
} sync_t;

typedef struct packed {
    logic [3:0] x;                          // pixel within line
    logic [2:0] y;                          // line within frame
} pos_t;

typedef logic [`PAL_AWIDTH-1:0] pal_index_t;

typedef struct packed {
    pal_index_t index_a;                    // playfield a entry
    pal_index_t index_b;                    // playfield b entry
} pf_index_t;

// palette entry, mode bit on top
typedef struct packed {
    logic       mode;                       // blend mode bit
    logic [2:0] unused;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
} xrgb_t;

typedef struct packed {
    xrgb_t color_a;
    xrgb_t color_b;
} xrgb_pair_t;

endpackage

// ==== reg_types_pkg.sv ====
`include "video_consts.svh"

package reg_types_pkg;

typedef enum logic [3:0] {
    REG_INTR_MASK   = 4'(`REG_INTR_MASK),
    REG_INTR_CLEAR  = 4'(`REG_INTR_CLEAR),
    REG_SCROLL_A    = 4'(`REG_SCROLL_A),
    REG_SCROLL_B    = 4'(`REG_SCROLL_B),
    REG_PAL_ADDR    = 4'(`REG_PAL_ADDR),
    REG_PAL_DATA    = 4'(`REG_PAL_DATA),
    REG_LINE_CMP    = 4'(`REG_LINE_CMP)
} reg_num_t;

// interrupt bits, 2 and 3 reserved
typedef logic [3:0] intr_t;

localparam int INTR_VBLANK = 0;
localparam int INTR_LINE   = 1;

typedef struct packed {
    logic [`PAL_AWIDTH-1:0] scroll_a;       // playfield a offset
    logic [`PAL_AWIDTH-1:0] scroll_b;       // playfield b offset
    logic [2:0]             line_cmp;       // line for compare irq
    intr_t                  intr_mask;      // enabled irq sources
} ctrl_t;

endpackage

// ==== vid_stage_if.sv ====
`timescale 1ns/1ps

// one pixel per clock, no valid, de marks visible
interface vid_stage_if #(
    parameter type payload_t = vid_types_pkg::pos_t
);

vid_types_pkg::sync_t   sync;               // syncs of this pixel
payload_t               payload;            // stage data of this pixel

// producer side
modport src (
    output sync,
    output payload
);

// consumer side, also used by monitors
modport dst (
    input  sync,
    input  payload
);

endinterface

// ==== video_timing.sv ====
`timescale 1ns/1ps
`include "video_consts.svh"

module video_timing (
    input  wire logic   clk,                // pixel clock
    input  wire logic   reset_i,            // sync reset
    vid_stage_if.src    tim_o               // position and syncs out
);

vid_types_pkg::pos_t    pos_q;              // current position
vid_types_pkg::pos_t    pos_nxt;            // position next clock
vid_types_pkg::sync_t   sync_q;             // syncs for pos_q

// syncs for a given position
function automatic vid_types_pkg::sync_t sync_at(input logic [3:0] x, input logic [2:0] y);
    vid_types_pkg::sync_t s;
    s.de    = (x < 4'(`H_VISIBLE)) && (y < 3'(`V_VISIBLE));
    s.hsync = (x >= 4'(`H_VISIBLE + `H_FRONT)) &&
              (x <  4'(`H_VISIBLE + `H_FRONT + `H_SYNC));
    s.vsync = (y >= 3'(`V_VISIBLE + `V_FRONT)) &&
              (y <  3'(`V_VISIBLE + `V_FRONT + `V_SYNC));
    return s;
endfunction

// next pixel, wrap at line and frame end
always_comb begin
    pos_nxt = pos_q;
    if (pos_q.x == 4'(`H_TOTAL - 1)) begin
        pos_nxt.x = 4'd0;                   // new line
        if (pos_q.y == 3'(`V_TOTAL - 1)) begin
            pos_nxt.y = 3'd0;               // new frame
        end else begin
            pos_nxt.y = pos_q.y + 3'd1;
        end
    end else begin
        pos_nxt.x = pos_q.x + 4'd1;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        pos_q  <= '0;                       // start at x 0, y 0
        sync_q <= sync_at(4'd0, 3'd0);      // syncs match reset position
    end else begin
        pos_q  <= pos_nxt;
        sync_q <= sync_at(pos_nxt.x, pos_nxt.y);
    end
end

assign tim_o.payload = pos_q;
assign tim_o.sync    = sync_q;

endmodule

// ==== playfield_index.sv ====
`timescale 1ns/1ps
`include "video_consts.svh"

module playfield_index (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic [`PAL_AWIDTH-1:0]     scroll_a_i,     // playfield a offset
    input  wire logic [`PAL_AWIDTH-1:0]     scroll_b_i,     // playfield b offset
    vid_stage_if.dst                        tim_i,          // position in
    vid_stage_if.src                        idx_o           // palette indices out
);

vid_types_pkg::pal_index_t  base_idx;       // unscrolled index
vid_types_pkg::pf_index_t   idx_nxt;

// x + 8*y, 8 pixels per visible line
assign base_idx = {2'b00, tim_i.payload.x} + {tim_i.payload.y, 3'b000};

always_comb begin
    idx_nxt.index_a = base_idx + scroll_a_i;    // wraps mod 64
    idx_nxt.index_b = base_idx + scroll_b_i;
end

// syncs follow the pixel
always_ff @(posedge clk) begin
    if (reset_i) begin
        idx_o.sync <= '0;
    end else begin
        idx_o.sync <= tim_i.sync;
    end
end

always_ff @(posedge clk) begin
    idx_o.payload <= idx_nxt;
end

endmodule

// ==== color_lookup.sv ====
`timescale 1ns/1ps
`include "video_consts.svh"

module color_lookup (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       pal_wr_i,       // palette write strobe
    input  wire logic                       pal_sel_i,      // 0 = palette a, 1 = palette b
    input  wire logic [`PAL_AWIDTH-1:0]     pal_addr_i,     // entry to write
    input  wire vid_types_pkg::xrgb_t       pal_data_i,     // entry value
    vid_stage_if.dst                        idx_i,          // indices in
    vid_stage_if.src                        col_o           // colour pair out
);

vid_types_pkg::xrgb_t   pal_a [`PAL_DEPTH];     // playfield a palette
vid_types_pkg::xrgb_t   pal_b [`PAL_DEPTH];     // playfield b palette
vid_types_pkg::xrgb_t   color_a_q;
vid_types_pkg::xrgb_t   color_b_q;

// palette a, write port from cpu side, read every clock
always_ff @(posedge clk) begin
    if (pal_wr_i && !pal_sel_i) begin
        pal_a[pal_addr_i] <= pal_data_i;
    end
    color_a_q <= pal_a[idx_i.payload.index_a];  // registered read
end

// palette b, same shape
always_ff @(posedge clk) begin
    if (pal_wr_i && pal_sel_i) begin
        pal_b[pal_addr_i] <= pal_data_i;
    end
    color_b_q <= pal_b[idx_i.payload.index_b];
end

// delay syncs to line up with read data
always_ff @(posedge clk) begin
    if (reset_i) begin
        col_o.sync <= '0;
    end else begin
        col_o.sync <= idx_i.sync;
    end
end

assign col_o.payload.color_a = color_a_q;
assign col_o.payload.color_b = color_b_q;

endmodule

// ==== pixel_blend.sv ====
`timescale 1ns/1ps

module pixel_blend (
    input  wire logic   clk,
    input  wire logic   reset_i,
    vid_stage_if.dst    col_i,                  // colour pair in
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o                 // display enable
);

vid_types_pkg::xrgb_t   col_a;
vid_types_pkg::xrgb_t   col_b;
logic [11:0]            rgb_mix;                // blended r, g, b

// a + b, stick at 15
function automatic logic [3:0] sat_add(input logic [3:0] a, input logic [3:0] b);
    logic [4:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[4] ? 4'hF : s[3:0];
endfunction

// a - b, stick at 0
function automatic logic [3:0] sat_sub(input logic [3:0] a, input logic [3:0] b);
    logic [4:0] s;
    s = {1'b0, a} - {1'b0, b};
    return s[4] ? 4'h0 : s[3:0];           // borrow means negative
endfunction

assign col_a = col_i.payload.color_a;
assign col_b = col_i.payload.color_b;

// mode from b and a mode bits
always_comb begin
    case ({col_b.mode, col_a.mode})
        2'b00:   rgb_mix = {col_a.r, col_a.g, col_a.b};
        2'b01:   rgb_mix = {col_b.r, col_b.g, col_b.b};
        2'b10:   rgb_mix = {sat_add(col_a.r, col_b.r),
                            sat_add(col_a.g, col_b.g),
                            sat_add(col_a.b, col_b.b)};
        default: rgb_mix = {sat_sub(col_a.r, col_b.r),
                            sat_sub(col_a.g, col_b.g),
                            sat_sub(col_a.b, col_b.b)};
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
    end else begin
        hsync_o <= col_i.sync.hsync;
        vsync_o <= col_i.sync.vsync;
        dv_de_o <= col_i.sync.de;
    end
end

// black outside the display area
always_ff @(posedge clk) begin
    if (col_i.sync.de) begin
        {red_o, green_o, blue_o} <= rgb_mix;
    end else begin
        {red_o, green_o, blue_o} <= 12'h000;
    end
end

endmodule

// ==== ctrl_regs.sv ====
`timescale 1ns/1ps
`include "video_consts.svh"

module ctrl_regs (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,       // write strobe
    input  wire logic [3:0]                 reg_num_i,      // register number
    input  wire logic [15:0]                reg_data_i,     // write data
    vid_stage_if.dst                        tim_i,          // timing monitor
    output logic [`PAL_AWIDTH-1:0]          scroll_a_o,
    output logic [`PAL_AWIDTH-1:0]          scroll_b_o,
    output logic                            pal_wr_o,       // palette write strobe
    output logic                            pal_sel_o,      // 1 = palette b
    output logic [`PAL_AWIDTH-1:0]          pal_addr_o,
    output vid_types_pkg::xrgb_t            pal_data_o,
    output logic                            bus_intr_o,     // cpu irq strobe
    output reg_types_pkg::intr_t            intr_status_o   // pending irqs
);

reg_types_pkg::reg_num_t    reg_num;
reg_types_pkg::ctrl_t       ctrl_q;
logic [`PAL_AWIDTH:0]       pal_addr_q;     // bit 6 picks palette b
reg_types_pkg::intr_t       intr_signal;    // events this cycle
reg_types_pkg::intr_t       intr_clear;     // cpu clear bits

assign reg_num = reg_types_pkg::reg_num_t'(reg_num_i);

// palette writes go straight through, land on this edge
assign pal_wr_o   = reg_wr_i && (reg_num == reg_types_pkg::REG_PAL_DATA);
assign pal_sel_o  = pal_addr_q[`PAL_AWIDTH];
assign pal_addr_o = pal_addr_q[`PAL_AWIDTH-1:0];
assign pal_data_o = vid_types_pkg::xrgb_t'(reg_data_i);

assign scroll_a_o = ctrl_q.scroll_a;
assign scroll_b_o = ctrl_q.scroll_b;

// register decode
always_ff @(posedge clk) begin
    if (reset_i) begin
        ctrl_q     <= '0;
        pal_addr_q <= '0;
    end else if (reg_wr_i) begin
        case (reg_num)
            reg_types_pkg::REG_INTR_MASK: ctrl_q.intr_mask <= reg_data_i[3:0];
            reg_types_pkg::REG_SCROLL_A:  ctrl_q.scroll_a  <= reg_data_i[`PAL_AWIDTH-1:0];
            reg_types_pkg::REG_SCROLL_B:  ctrl_q.scroll_b  <= reg_data_i[`PAL_AWIDTH-1:0];
            reg_types_pkg::REG_LINE_CMP:  ctrl_q.line_cmp  <= reg_data_i[2:0];
            reg_types_pkg::REG_PAL_ADDR:  pal_addr_q <= reg_data_i[`PAL_AWIDTH:0];
            reg_types_pkg::REG_PAL_DATA:  pal_addr_q <= pal_addr_q + 7'd1;  // wraps in 7 bits
            default: ;                      // intr clear handled below
        endcase
    end
end

// event detect on the timing stage output
always_comb begin
    intr_signal = '0;
    intr_signal[reg_types_pkg::INTR_VBLANK] = (tim_i.payload.x == 4'd0) &&
                                             (tim_i.payload.y == 3'(`V_VISIBLE));
    intr_signal[reg_types_pkg::INTR_LINE]   = (tim_i.payload.x == 4'd0) &&
                                             (tim_i.payload.y == ctrl_q.line_cmp);
    intr_clear = '0;
    if (reg_wr_i && (reg_num == reg_types_pkg::REG_INTR_CLEAR)) begin
        intr_clear = reg_data_i[3:0];
    end
end

// status and strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o    <= 1'b0;
        intr_status_o <= '0;
    end else begin
        // only new, enabled events fire
        bus_intr_o    <= |(intr_signal & ctrl_q.intr_mask & ~intr_status_o);
        intr_status_o <= (intr_status_o | intr_signal) & ~intr_clear;  // clear wins
    end
end

endmodule

// ==== video_main.sv ====
`timescale 1ns/1ps
`include "video_consts.svh"

module video_main (
    input  wire logic           clk,                // pixel clock
    input  wire logic           reset_i,            // sync reset
    input  wire logic           reg_wr_i,           // register write strobe
    input  wire logic [3:0]     reg_num_i,          // register number
    input  wire logic [15:0]    reg_data_i,         // register write data
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,            // display enable
    output logic                bus_intr_o,         // cpu irq strobe
    output reg_types_pkg::intr_t intr_status_o      // pending irqs
);

logic [`PAL_AWIDTH-1:0]     scroll_a;
logic [`PAL_AWIDTH-1:0]     scroll_b;
logic                       pal_wr;
logic                       pal_sel;
logic [`PAL_AWIDTH-1:0]     pal_addr;
vid_types_pkg::xrgb_t       pal_data;

// pixel path between stages
vid_stage_if #(.payload_t(vid_types_pkg::pos_t))       tim_if ();
vid_stage_if #(.payload_t(vid_types_pkg::pf_index_t))  idx_if ();
vid_stage_if #(.payload_t(vid_types_pkg::xrgb_pair_t)) col_if ();

video_timing u_timing (
    .clk            (clk),
    .reset_i        (reset_i),
    .tim_o          (tim_if.src)
);

playfield_index u_index (
    .clk            (clk),
    .reset_i        (reset_i),
    .scroll_a_i     (scroll_a),
    .scroll_b_i     (scroll_b),
    .tim_i          (tim_if.dst),
    .idx_o          (idx_if.src)
);

color_lookup u_lookup (
    .clk            (clk),
    .reset_i        (reset_i),
    .pal_wr_i       (pal_wr),
    .pal_sel_i      (pal_sel),
    .pal_addr_i     (pal_addr),
    .pal_data_i     (pal_data),
    .idx_i          (idx_if.dst),
    .col_o          (col_if.src)
);

pixel_blend u_blend (
    .clk            (clk),
    .reset_i        (reset_i),
    .col_i          (col_if.dst),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o)
);

// registers and irqs, watches the timing stage
ctrl_regs u_ctrl (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_i       (reg_wr_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .tim_i          (tim_if.dst),
    .scroll_a_o     (scroll_a),
    .scroll_b_o     (scroll_b),
    .pal_wr_o       (pal_wr),
    .pal_sel_o      (pal_sel),
    .pal_addr_o     (pal_addr),
    .pal_data_o     (pal_data),
    .bus_intr_o     (bus_intr_o),
    .intr_status_o  (intr_status_o)
);

endmodule

// ==== tb_video_main.sv ====
`timescale 1ns/1ps
`include "video_consts.svh"

module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic clk_o
);

initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;    // 50/50 duty
end

endmodule

module tb_video_main;

localparam int frame_cycles = `H_TOTAL * `V_TOTAL;     // 98 for the tiny mode
localparam int visible_pix  = `H_VISIBLE * `V_VISIBLE;
localparam int vsync_cycles = `V_SYNC * `H_TOTAL;

logic        clk;
logic        reset;
logic        reg_wr;
logic [3:0]  reg_num;
logic [15:0] reg_data;
logic [3:0]  red;
logic [3:0]  green;
logic [3:0]  blue;
logic        hsync;
logic        vsync;
logic        dv_de;
logic        bus_intr;
logic [3:0]  intr_status;

// reference state, built from the writes on the bus
logic [3:0]  m_x;                           // timing stage position
logic [2:0]  m_y;
logic [5:0]  m_scroll_a;
logic [5:0]  m_scroll_b;
logic [2:0]  m_line;
logic [3:0]  m_mask;
logic [3:0]  m_status;
logic        m_intr;                        // expected irq strobe
logic [6:0]  m_pal_addr;                    // bit 6 = palette b
logic [15:0] m_pal_a [0:63];
logic [15:0] m_pal_b [0:63];

int test_errs;
int total_errs;
int tests_run;
int tests_failed;
int checks;
int budget_cycles;

tb_clock_gen #(.period_ns(100)) u_clk (.clk_o(clk));

video_main u_dut (
    .clk            (clk),
    .reset_i        (reset),
    .reg_wr_i       (reg_wr),
    .reg_num_i      (reg_num),
    .reg_data_i     (reg_data),
    .red_o          (red),
    .green_o        (green),
    .blue_o         (blue),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .dv_de_o        (dv_de),
    .bus_intr_o     (bus_intr),
    .intr_status_o  (intr_status)
);

// samples the bus like the DUT does, old values at the edge
always @(posedge clk) begin : ref_model
    logic [3:0] ev;
    logic [3:0] clr;
    ev    = 4'h0;
    clr   = 4'h0;
    ev[0] = (m_x == 4'd0) && (m_y == 3'(`V_VISIBLE));   // vblank start
    ev[1] = (m_x == 4'd0) && (m_y == m_line);           // line compare
    if (reg_wr && (reg_num == 4'(`REG_INTR_CLEAR))) begin
        clr = reg_data[3:0];
    end
    if (reset) begin
        m_x        <= 4'd0;
        m_y        <= 3'd0;
        m_scroll_a <= 6'd0;
        m_scroll_b <= 6'd0;
        m_line     <= 3'd0;
        m_mask     <= 4'h0;
        m_status   <= 4'h0;
        m_intr     <= 1'b0;
        m_pal_addr <= 7'd0;
    end else begin
        if (m_x != 4'(`H_TOTAL - 1)) begin
            m_x <= m_x + 4'd1;
        end else begin
            m_x <= 4'd0;
            m_y <= (m_y == 3'(`V_TOTAL - 1)) ? 3'd0 : m_y + 3'd1;
        end
        if (reg_wr) begin
            case (reg_num)
                4'(`REG_INTR_MASK): m_mask     <= reg_data[3:0];
                4'(`REG_SCROLL_A):  m_scroll_a <= reg_data[5:0];
                4'(`REG_SCROLL_B):  m_scroll_b <= reg_data[5:0];
                4'(`REG_LINE_CMP):  m_line     <= reg_data[2:0];
                4'(`REG_PAL_ADDR):  m_pal_addr <= reg_data[6:0];
                4'(`REG_PAL_DATA): begin
                    if (m_pal_addr[6]) begin
                        m_pal_b[m_pal_addr[5:0]] <= reg_data;
                    end else begin
                        m_pal_a[m_pal_addr[5:0]] <= reg_data;
                    end
                    m_pal_addr <= m_pal_addr + 7'd1;    // 7-bit wrap
                end
                default: ;
            endcase
        end
        m_intr   <= |(ev & m_mask & ~m_status);  // new enabled events only
        m_status <= (m_status | ev) & ~clr;
    end
end

// per channel: select a, select b, add to 15, subtract to 0
function automatic logic [11:0] blend_rgb(input logic [15:0] a, input logic [15:0] b);
    int          k;
    int          ch_a;
    int          ch_b;
    int          v;
    logic [11:0] rgb;
    rgb = 12'h000;
    for (k = 0; k < 3; k++) begin
        ch_a = int'(a[k*4 +: 4]);
        ch_b = int'(b[k*4 +: 4]);
        if (!a[15] && !b[15]) begin
            v = ch_a;
        end else if (a[15] && !b[15]) begin
            v = ch_b;
        end else if (!a[15] && b[15]) begin
            v = (ch_a + ch_b > 15) ? 15 : ch_a + ch_b;
        end else begin
            v = (ch_a < ch_b) ? 0 : ch_a - ch_b;
        end
        rgb[k*4 +: 4] = 4'(v);
    end
    return rgb;
endfunction

function automatic string test_name(input int id);
    case (id)
        1:       return "playfield a";
        2:       return "scrolling";
        3:       return "blend modes";
        4:       return "syncs";
        5:       return "interrupts";
        default: return "unknown";
    endcase
endfunction

task automatic write_reg(input logic [3:0] num, input logic [15:0] data);
    @(posedge clk);
    reg_wr   <= 1'b1;
    reg_num  <= num;
    reg_data <= data;
endtask

task automatic bus_idle();
    @(posedge clk);
    reg_wr <= 1'b0;
endtask

// odd step of 91 gives 64 distinct entries
task automatic fill_palette(input logic sel, input logic [15:0] base);
    int i;
    write_reg(4'(`REG_PAL_ADDR), {9'h000, sel, 6'h00});
    for (i = 0; i < `PAL_DEPTH; i++) begin
        write_reg(4'(`REG_PAL_DATA), {base[15:12], 12'(int'(base[11:0]) + i * 91)});
    end
endtask

task automatic wait_vsync_rise(output bit found);
    bit prev;
    int n;
    prev  = 1'b1;                           // already in vsync does not count
    n     = 0;
    found = 1'b0;
    while (!found && n < 2 * frame_cycles) begin
        @(negedge clk);
        found = !prev && vsync;
        prev  = vsync;
        n++;
    end
endtask

// n-th active pixel is x = n mod 8, y = n / 8
task automatic check_pixel(input int n, input bit want_de);
    int          x;
    int          y;
    logic [5:0]  ia;
    logic [5:0]  ib;
    logic [11:0] want;
    x    = n % 8;
    y    = n / 8;
    want = 12'h000;                         // black when blanked
    if (want_de) begin
        ia   = 6'(x + 8 * y + int'(m_scroll_a));    // mod 64
        ib   = 6'(x + 8 * y + int'(m_scroll_b));
        want = blend_rgb(m_pal_a[ia], m_pal_b[ib]);
    end
    checks++;
    assert ({red, green, blue} == want) else begin
        $display("mismatch {red_o,green_o,blue_o} de %0b x %0d y %0d: got 0x%h expected 0x%h",
                 dv_de, x, y, {red, green, blue}, want);
        test_errs++;
    end
endtask

// one frame, from a vsync rise up to the next
task automatic scan_frame(input bit do_pixels);
    int cyc;
    int n_de;
    int n_exp;
    int n_hs;
    int hs_len;
    int vs_len;
    int pix_x;
    int line_y;
    bit want_de;
    bit prev_vs;
    bit rose;
    cyc    = 0;
    n_de   = 0;
    n_exp  = 0;
    n_hs   = 0;
    hs_len = 0;
    vs_len = 0;
    rose   = 1'b0;
    while (!rose && cyc < 2 * frame_cycles) begin
        if (vsync) vs_len++;
        if (hsync) begin
            hs_len++;
        end else if (hs_len != 0) begin     // pulse just ended
            assert (hs_len == `H_SYNC) else begin
                $display("mismatch hsync_o width: got 0x%0h expected 0x%0h", hs_len, `H_SYNC);
                test_errs++;
            end
            n_hs++;
            hs_len = 0;
        end
        // the vsync rise is pixel 0 of the first vsync line
        pix_x   = cyc % `H_TOTAL;
        line_y  = (`V_VISIBLE + `V_FRONT + cyc / `H_TOTAL) % `V_TOTAL;
        want_de = (pix_x < `H_VISIBLE) && (line_y < `V_VISIBLE);
        checks++;
        assert (dv_de == want_de) else begin
            $display("mismatch dv_de_o x %0d y %0d: got 0x%h expected 0x%h",
                     pix_x, line_y, dv_de, want_de);
            test_errs++;
        end
        if (do_pixels) check_pixel(n_exp, want_de);
        if (dv_de) n_de++;
        if (want_de) n_exp++;
        prev_vs = vsync;
        @(negedge clk);
        cyc++;
        rose = !prev_vs && vsync;
    end
    checks += 4;
    assert (cyc == frame_cycles) else begin
        $display("mismatch vsync_o period: got 0x%0h expected 0x%0h", cyc, frame_cycles);
        test_errs++;
    end
    assert (n_de == visible_pix) else begin
        $display("mismatch dv_de_o count: got 0x%0h expected 0x%0h", n_de, visible_pix);
        test_errs++;
    end
    assert (n_hs == `V_TOTAL) else begin
        $display("mismatch hsync_o pulses: got 0x%0h expected 0x%0h", n_hs, `V_TOTAL);
        test_errs++;
    end
    assert (vs_len == vsync_cycles) else begin
        $display("mismatch vsync_o width: got 0x%0h expected 0x%0h", vs_len, vsync_cycles);
        test_errs++;
    end
endtask

// cycle by cycle against the reference, plus the pulse count from the file
task automatic check_intr(input int frames, input int want_pulses);
    int pulses;
    pulses = 0;
    repeat (frames * frame_cycles) begin
        @(negedge clk);
        checks += 2;
        assert (bus_intr == m_intr) else begin
            $display("mismatch bus_intr_o: got 0x%h expected 0x%h", bus_intr, m_intr);
            test_errs++;
        end
        assert (intr_status == m_status) else begin
            $display("mismatch intr_status_o: got 0x%h expected 0x%h", intr_status, m_status);
            test_errs++;
        end
        if (bus_intr) pulses++;
    end
    checks++;
    assert (pulses == want_pulses) else begin
        $display("mismatch bus_intr_o pulses: got 0x%0h expected 0x%0h", pulses, want_pulses);
        test_errs++;
    end
endtask

task automatic run_check(input int id, input int frames, input int pulses);
    bit found;
    test_errs = 0;
    bus_idle();
    if (id == 5) begin
        check_intr(frames, pulses);
    end else if (id >= 1 && id <= 4) begin
        wait_vsync_rise(found);
        if (!found) begin
            $display("vsync_o did not rise within two frames");
            test_errs++;
        end else begin
            repeat (frames) scan_frame(id != 4);    // test 4 looks at syncs only
        end
    end else begin
        $display("unknown test number %0d in input file", id);
        test_errs++;
    end
    tests_run++;
    if (test_errs != 0) tests_failed++;
    total_errs += test_errs;
    $display("test %0d %s, %0d frame(s): %s, %0d error(s)", id, test_name(id), frames,
             (test_errs == 0) ? "ok" : "failed", test_errs);
endtask

// ends the run if the file takes far longer than its length allows
initial begin : watchdog
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", budget_cycles);
    $display("Result: FAILED");
    $finish;
end

initial begin : main
    int         fd;
    int         n_lines;
    int         line_no;
    int         n;
    int         a;
    int         b;
    int         c;
    string      line;
    logic [7:0] op;
    bit         file_ok;
    reset        = 1'b1;
    reg_wr       = 1'b0;
    reg_num      = 4'h0;
    reg_data     = 16'h0000;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    n_lines      = 0;
    line_no      = 0;
    file_ok      = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checks++;
    assert ({dv_de, hsync, vsync, bus_intr, intr_status} == 8'h00) else begin
        $display("mismatch outputs in reset: got 0x%h expected 0x00",
                 {dv_de, hsync, vsync, bus_intr, intr_status});
        total_errs++;
    end
    @(posedge clk);
    reset <= 1'b0;                          // third edge in reset
    fd = $fopen("video_input.txt", "r");
    if (fd == 0) begin
        $display("could not open video_input.txt");
    end else begin
        file_ok = 1'b1;
        while ($fgets(line, fd) != 0) n_lines++;
        $fclose(fd);
        budget_cycles = n_lines * 2 * frame_cycles + 10 * frame_cycles;
        fd = $fopen("video_input.txt", "r");
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            op = line.getc(0);
            a  = 0;
            b  = 0;
            c  = 0;
            n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            if (n != 3) begin
                $display("input line %0d does not hold three hex fields", line_no);
                total_errs++;
            end else if (op == "w") begin
                write_reg(4'(a), 16'(b));
            end else if (op == "f") begin
                fill_palette(a[0], 16'(b));
            end else if (op == "c") begin
                run_check(a, b, c);
            end else begin
                $display("input line %0d has an unknown operation", line_no);
                total_errs++;
            end
        end
        $fclose(fd);
        bus_idle();
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errs);
    if (file_ok && tests_run > 0 && total_errs == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

// ==== video_input.txt ====
# op a b c in hex: w = write register a with b, f = fill palette a (0 = A, 1 = B) from base b
# c = run test a over b frames, c = expected bus_intr_o pulses (test 5 only)
f 0 0000 0
f 1 0fff 0
c 1 2 0
w 2 0005 0
w 3 0021 0
c 2 1 0
w 2 0000 0
w 3 0000 0
f 1 8456 0
# address wrapped to A entry 0, one entry per mode pair
w 5 0123 0
w 5 8f85 0
w 5 0c9e 0
w 5 83a7 0
w 4 0040 0
w 5 0abc 0
w 5 0456 0
w 5 8531 0
w 5 8527 0
c 3 1 0
c 4 2 0
w 6 0002 0
w 0 0003 0
w 1 000f 0
c 5 2 2
c 5 2 0
w 1 0001 0
c 5 2 1
w 0 0002 0
w 1 0003 0
c 5 2 1
w 0 0000 0
w 1 0003 0
c 5 2 0

// ==== compile.f ====
+incdir+.
vid_types_pkg.sv
reg_types_pkg.sv
vid_stage_if.sv
video_timing.sv
playfield_index.sv
color_lookup.sv
pixel_blend.sv
ctrl_regs.sv
video_main.sv
tb_video_main.sv

// ==== Makefile ====
# Verilator build and run for the video back end

VERILATOR ?= verilator
TOP       ?= tb_video_main
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
